/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = epu_tb
FILELIST = epu.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* epu.f */
logic/epu_pkg.sv
logic/epu_commit_if.sv
logic/epu_msr_if.sv
logic/epu_decode_stage.sv
logic/epu_commit_stage.sv
logic/epu_msr_bank.sv
logic/epu_top.sv
verif/epu_tb.sv

/* logic/epu_commit_if.sv */
/*
 * EPU commit bundle
 * Item held in the decode stage register and consumed by the commit stage
 */
`timescale 1ns/100ps

interface epu_commit_if;
   import epu_pkg::*;

   logic     valid;
   // Flags already qualified by valid
   fe_t      fe;
   wmsr_we_t we;
   sr_sel_t  sr_sel;
   data_t    wdat;
   pc_t      pc;
   pc_t      npc;

   modport decode (
      output valid, fe, we, sr_sel, wdat, pc, npc
   );

   modport commit (
      input  valid, fe, we, sr_sel, wdat, pc, npc
   );

endinterface

/* logic/epu_commit_stage.sv */
/*
 * EPU commit stage
 * MSR write strobes, PSR save and restore, pipeline flush and its target
 */
`timescale 1ns/100ps

module epu_commit_stage (
   input  logic           p_ce_s2,
   epu_commit_if.commit   cmt,
   input  logic           s2_edtm,
   input  logic           s2_edpf,
   input  logic           s2_ealign,
   input  epu_pkg::data_t s2_vaddr,
   epu_msr_if.writer      msr,
   output logic           wb_valid,
   output logic           exc_flush,
   output epu_pkg::pc_t   exc_flush_tgt
);
   import epu_pkg::*;

   fe_t      fe;
   wmsr_we_t we;
   logic     edtm;
   logic     edpf;
   logic     ealign;
   logic     data_fault;
   logic     elsa_pc;
   data_t    pc_byte;
   data_t    npc_byte;

   // Vector page of EVECT joined with the cause offset
   function automatic pc_t vec_pc(input data_t evect,
                                  input logic [EXCP_VECT_W-1:0] vec);
      return {evect[DW-1:EXCP_VECT_W], vec[EXCP_VECT_W-1:INSN_LEN_LOG2]};
   endfunction

   // Nothing leaves this stage while it is stalled
   assign fe         = cmt.fe & {$bits(fe_t){p_ce_s2}};
   assign we         = cmt.we & {$bits(wmsr_we_t){p_ce_s2}};
   assign edtm       = p_ce_s2 & s2_edtm;
   assign edpf       = p_ce_s2 & s2_edpf;
   assign ealign     = p_ce_s2 & s2_ealign;
   assign data_fault = edtm | edpf | ealign;
   assign pc_byte    = {cmt.pc, {INSN_LEN_LOG2{1'b0}}};
   assign npc_byte   = {cmt.npc, {INSN_LEN_LOG2{1'b0}}};

   //////////////////////////////////////////////////////////////////////
   // MSR updates

   // Every cause except ERET saves PSR
   assign msr.save     = fe.esyscall | fe.einsn | fe.eipf | fe.eitm | fe.eirq | data_fault;
   assign msr.restore  = fe.eret;
   assign msr.psr_we   = we.psr;
   assign msr.epsr_we  = we.epsr;
   assign msr.evect_we = we.evect;
   assign msr.sr_we    = cmt.sr_sel & {SR_NUM{we.sr}};
   assign msr.wmsr_dat = cmt.wdat;

   // Syscall returns past itself
   assign msr.epc_nxt = we.epc ? cmt.wdat : (fe.esyscall ? npc_byte : pc_byte);
   assign msr.epc_we  = msr.save | we.epc;

   // Fetch side faults and EINSN record the PC in ELSA
   assign elsa_pc      = fe.eitm | fe.eipf | fe.einsn;
   assign msr.elsa_nxt = elsa_pc ? pc_byte : (data_fault ? s2_vaddr : cmt.wdat);
   assign msr.elsa_we  = elsa_pc | data_fault | we.elsa;

   //////////////////////////////////////////////////////////////////////
   // Flush

   // Causes are one-hot
   assign exc_flush_tgt = ({PC_W{fe.einsn}}    & vec_pc(msr.evect, VEC_EINSN))    |
                          ({PC_W{fe.eitm}}     & vec_pc(msr.evect, VEC_EITM))     |
                          ({PC_W{fe.eipf}}     & vec_pc(msr.evect, VEC_EIPF))     |
                          ({PC_W{fe.esyscall}} & vec_pc(msr.evect, VEC_ESYSCALL)) |
                          ({PC_W{fe.eirq}}     & vec_pc(msr.evect, VEC_EIRQ))     |
                          ({PC_W{edtm}}        & vec_pc(msr.evect, VEC_EDTM))     |
                          ({PC_W{edpf}}        & vec_pc(msr.evect, VEC_EDPF))     |
                          ({PC_W{ealign}}      & vec_pc(msr.evect, VEC_EALIGN))   |
                          ({PC_W{fe.eret}}     & msr.epc[DW-1:INSN_LEN_LOG2])     |
                          ({PC_W{we.psr}}      & cmt.npc);

   // A PSR write refetches from the next instruction
   assign exc_flush = (|fe) | data_fault | we.psr;
   assign wb_valid  = cmt.valid & p_ce_s2;

endmodule

/* logic/epu_decode_stage.sv */
/*
 * EPU decode stage
 * MSR address decode, read multiplexer and the stage register
 */
`timescale 1ns/100ps

module epu_decode_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              p_ce_s1,
   input  logic              cmt_valid,
   input  epu_pkg::epu_opc_t cmt_opc,
   input  epu_pkg::fe_t      cmt_fe,
   input  epu_pkg::pc_t      cmt_pc,
   input  epu_pkg::pc_t      cmt_npc,
   input  epu_pkg::data_t    cmt_addr,
   input  epu_pkg::data_t    cmt_wdat,
   epu_msr_if.reader         msr,
   epu_commit_if.decode      cmt,
   output epu_pkg::data_t    wb_dout,
   output logic              wb_dout_sel
);
   import epu_pkg::*;

   logic [BANK_AW-1:0]     bank_num;
   logic [BANK_OFF_AW-1:0] bank_off;
   logic                   bank_ps;
   logic                   bank_sr;
   logic                   wmsr;
   data_t                  dout_ps;
   data_t                  dout_sr;
   data_t                  dout;
   wmsr_we_t               we;

   assign bank_num = cmt_addr[BANK_OFF_AW +: BANK_AW];
   assign bank_off = cmt_addr[BANK_OFF_AW-1:0];
   assign bank_ps  = (bank_num == BANK_PS);
   assign bank_sr  = (bank_num == BANK_SR);

   //////////////////////////////////////////////////////////////////////
   // Read multiplexer

   // PS bank ORs every selected register
   assign dout_ps = ({DW{bank_off[OFF_PSR]}}    & {{(DW-PSR_DW){1'b0}}, msr.psr})  |
                    ({DW{bank_off[OFF_CPUID]}}  & CPUID_VAL)                       |
                    ({DW{bank_off[OFF_EPSR]}}   & {{(DW-PSR_DW){1'b0}}, msr.epsr}) |
                    ({DW{bank_off[OFF_EPC]}}    & msr.epc)                         |
                    ({DW{bank_off[OFF_ELSA]}}   & msr.elsa)                        |
                    ({DW{bank_off[OFF_COREID]}} & COREID_VAL);

   // Lowest selected SR wins
   always_comb
   begin
      dout_sr = '0;
      for (int i = SR_NUM-1; i >= 0; i--)
      begin
         if (bank_off[i])
            dout_sr = msr.sr[i];
      end
   end

   assign dout = ({DW{bank_ps}} & dout_ps) | ({DW{bank_sr}} & dout_sr);

   //////////////////////////////////////////////////////////////////////
   // Write enables

   assign wmsr     = cmt_valid & cmt_opc.wmsr;
   assign we.psr   = wmsr & bank_ps & bank_off[OFF_PSR];
   assign we.epc   = wmsr & bank_ps & bank_off[OFF_EPC];
   assign we.epsr  = wmsr & bank_ps & bank_off[OFF_EPSR];
   assign we.elsa  = wmsr & bank_ps & bank_off[OFF_ELSA];
   assign we.evect = wmsr & bank_ps & bank_off[OFF_EVECT];
   assign we.sr    = wmsr & bank_sr;

   //////////////////////////////////////////////////////////////////////
   // Stage register

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cmt.valid   <= 1'b0;
         cmt.fe      <= '0;
         cmt.we      <= '0;
         wb_dout_sel <= 1'b0;
      end
      else if (p_ce_s1)
      begin
         cmt.valid   <= cmt_valid;
         cmt.fe      <= cmt_fe & {$bits(fe_t){cmt_valid}};
         cmt.we      <= we;
         wb_dout_sel <= cmt_valid & cmt_opc.rmsr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce_s1)
      begin
         cmt.sr_sel <= bank_off[SR_NUM-1:0];
         cmt.wdat   <= cmt_wdat;
         cmt.pc     <= cmt_pc;
         cmt.npc    <= cmt_npc;
         wb_dout    <= dout;
      end
   end

endmodule

/* logic/epu_msr_bank.sv */
/*
 * EPU processor status bank
 * PSR, EPSR, EPC, ELSA, EVECT and scratch registers
 */
`timescale 1ns/100ps

module epu_msr_bank (
   input  logic          clk,
   input  logic          arst_n,
   epu_msr_if.bank       msr,
   output epu_pkg::psr_t psr
);
   import epu_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // PSR and EPSR

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         msr.psr <= PSR_RST;
      else if (msr.save)
      begin
         // Enter root mode with IRQs and MMUs off
         msr.psr.rm   <= 1'b1;
         msr.psr.ire  <= 1'b0;
         msr.psr.imme <= 1'b0;
         msr.psr.dmme <= 1'b0;
      end
      else if (msr.restore)
         msr.psr <= msr.epsr;
      else if (msr.psr_we)
         msr.psr[PSR_DW-1:PSR_FLAGS_W] <= msr.wmsr_dat[PSR_DW-1:PSR_FLAGS_W];
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         msr.epsr <= '0;
      else if (msr.save)
         msr.epsr <= msr.psr;
      else if (msr.epsr_we)
         msr.epsr <= msr.wmsr_dat[PSR_DW-1:0];
   end

   //////////////////////////////////////////////////////////////////////
   // Exception address registers

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         msr.epc   <= '0;
         msr.elsa  <= '0;
         msr.evect <= '0;
      end
      else
      begin
         if (msr.epc_we)
            msr.epc <= msr.epc_nxt;
         if (msr.elsa_we)
            msr.elsa <= msr.elsa_nxt;
         if (msr.evect_we)
            msr.evect <= msr.wmsr_dat;
      end
   end

   // Scratch registers
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < SR_NUM; i++)
            msr.sr[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < SR_NUM; i++)
         begin
            if (msr.sr_we[i])
               msr.sr[i] <= msr.wmsr_dat;
         end
      end
   end

   assign psr = msr.psr;

endmodule

/* logic/epu_msr_if.sv */
/*
 * EPU MSR bundle
 * Register state from the bank and write strobes from the commit stage
 */
`timescale 1ns/100ps

interface epu_msr_if;
   import epu_pkg::*;

   // Bank state
   psr_t    psr;
   psr_t    epsr;
   data_t   epc;
   data_t   elsa;
   data_t   evect;
   data_t   sr [SR_NUM];

   // Write strobes and next values
   logic    psr_we;
   logic    epsr_we;
   logic    evect_we;
   sr_sel_t sr_we;
   data_t   wmsr_dat;
   logic    epc_we;
   data_t   epc_nxt;
   logic    elsa_we;
   data_t   elsa_nxt;
   logic    save;
   logic    restore;

   modport bank (
      output psr, epsr, epc, elsa, evect, sr,
      input  psr_we, epsr_we, evect_we, sr_we, wmsr_dat,
             epc_we, epc_nxt, elsa_we, elsa_nxt, save, restore
   );

   // EVECT is write only from software
   modport reader (
      input  psr, epsr, epc, elsa, sr
   );

   modport writer (
      output psr_we, epsr_we, evect_we, sr_we, wmsr_dat,
             epc_we, epc_nxt, elsa_we, elsa_nxt, save, restore,
      input  epc, evect
   );

endinterface

/* logic/epu_pkg.sv */
/*
 * EPU shared definitions
 * Widths, MSR bank map, exception vectors, reset values and packed types
 */
package epu_pkg;

   // Widths
   localparam int DW            = 32;
   localparam int INSN_LEN_LOG2 = 2;
   localparam int PC_W          = DW - INSN_LEN_LOG2;
   localparam int PSR_DW        = 10;
   localparam int PSR_FLAGS_W   = 4;
   localparam int BANK_AW       = 4;
   localparam int BANK_OFF_AW   = 9;
   localparam int SR_NUM        = 4;
   localparam int EXCP_VECT_W   = 8;

   typedef logic [DW-1:0]     data_t;
   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [SR_NUM-1:0] sr_sel_t;

   typedef struct packed {
      logic                   dce;
      logic                   ice;
      logic                   dmme;
      logic                   imme;
      logic                   ire;
      logic                   rm;
      logic [PSR_FLAGS_W-1:0] flags;
   } psr_t;

   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
   } fe_t;

   typedef struct packed {
      logic rmsr;
      logic wmsr;
   } epu_opc_t;

   typedef struct packed {
      logic psr;
      logic epc;
      logic epsr;
      logic elsa;
      logic evect;
      logic sr;
   } wmsr_we_t;

   // Bank numbers
   localparam logic [BANK_AW-1:0] BANK_PS = 4'd0;
   localparam logic [BANK_AW-1:0] BANK_SR = 4'd8;

   // One offset bit per register in the PS bank
   localparam int OFF_PSR    = 0;
   localparam int OFF_CPUID  = 1;
   localparam int OFF_EPSR   = 2;
   localparam int OFF_EPC    = 3;
   localparam int OFF_ELSA   = 4;
   localparam int OFF_EVECT  = 5;
   localparam int OFF_COREID = 6;

   localparam data_t CPUID_VAL  = 32'h4550_0100;
   localparam data_t COREID_VAL = 32'h0000_0001;

   // Low vector bits per cause
   localparam logic [EXCP_VECT_W-1:0] VEC_EINSN    = 8'h04;
   localparam logic [EXCP_VECT_W-1:0] VEC_EITM     = 8'h08;
   localparam logic [EXCP_VECT_W-1:0] VEC_EIPF     = 8'h0C;
   localparam logic [EXCP_VECT_W-1:0] VEC_ESYSCALL = 8'h10;
   localparam logic [EXCP_VECT_W-1:0] VEC_EIRQ     = 8'h14;
   localparam logic [EXCP_VECT_W-1:0] VEC_EDTM     = 8'h18;
   localparam logic [EXCP_VECT_W-1:0] VEC_EDPF     = 8'h1C;
   localparam logic [EXCP_VECT_W-1:0] VEC_EALIGN   = 8'h20;

   // Core comes up in root mode
   localparam psr_t PSR_RST = '{rm: 1'b1, default: '0};

endpackage

/* logic/epu_top.sv */
/*
 * EPU top level
 * Decode stage, commit stage and status bank
 */
`timescale 1ns/100ps

module epu_top (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              p_ce_s1,
   input  logic              p_ce_s2,
   input  logic              cmt_valid,
   input  epu_pkg::epu_opc_t cmt_opc,
   input  epu_pkg::fe_t      cmt_fe,
   input  epu_pkg::pc_t      cmt_pc,
   input  epu_pkg::pc_t      cmt_npc,
   input  epu_pkg::data_t    cmt_addr,
   input  epu_pkg::data_t    cmt_wdat,
   input  logic              s2_edtm,
   input  logic              s2_edpf,
   input  logic              s2_ealign,
   input  epu_pkg::data_t    s2_vaddr,
   output epu_pkg::data_t    wb_dout,
   output logic              wb_dout_sel,
   output logic              wb_valid,
   output logic              exc_flush,
   output epu_pkg::pc_t      exc_flush_tgt,
   output epu_pkg::psr_t     msr_psr
);

   epu_msr_if    i_msr_if ();
   epu_commit_if i_cmt_if ();

   epu_decode_stage i_decode (
      .clk         (clk),
      .arst_n      (arst_n),
      .p_ce_s1     (p_ce_s1),
      .cmt_valid   (cmt_valid),
      .cmt_opc     (cmt_opc),
      .cmt_fe      (cmt_fe),
      .cmt_pc      (cmt_pc),
      .cmt_npc     (cmt_npc),
      .cmt_addr    (cmt_addr),
      .cmt_wdat    (cmt_wdat),
      .msr         (i_msr_if.reader),
      .cmt         (i_cmt_if.decode),
      .wb_dout     (wb_dout),
      .wb_dout_sel (wb_dout_sel)
   );

   epu_commit_stage i_commit (
      .p_ce_s2       (p_ce_s2),
      .cmt           (i_cmt_if.commit),
      .s2_edtm       (s2_edtm),
      .s2_edpf       (s2_edpf),
      .s2_ealign     (s2_ealign),
      .s2_vaddr      (s2_vaddr),
      .msr           (i_msr_if.writer),
      .wb_valid      (wb_valid),
      .exc_flush     (exc_flush),
      .exc_flush_tgt (exc_flush_tgt)
   );

   epu_msr_bank i_bank (
      .clk    (clk),
      .arst_n (arst_n),
      .msr    (i_msr_if.bank),
      .psr    (msr_psr)
   );

endmodule

/* verif/epu_tb.sv */
/*
 * EPU testbench
 * Directed tests of MSR access, exception entry, ERET and stalls
 */
`timescale 1ns/100ps

module epu_tb;
   import epu_pkg::*;

   localparam int           CLK_PERIOD      = 100;
   localparam int           DRIVE_DLY       = 10;
   localparam int           SAMPLE_DLY      = 40;
   localparam int           NUM_TESTS       = 6;
   localparam int           CYCLES_PER_TEST = 40;
   localparam logic [31:0]  SEED            = 32'h4f28_c0ea;
   localparam epu_opc_t     OPC_NONE        = '{rmsr: 1'b0, wmsr: 1'b0};
   localparam epu_opc_t     OPC_RD          = '{rmsr: 1'b1, wmsr: 1'b0};
   localparam epu_opc_t     OPC_WR          = '{rmsr: 1'b0, wmsr: 1'b1};

   logic     clk;
   logic     arst_n;
   logic     p_ce_s1;
   logic     p_ce_s2;
   logic     cmt_valid;
   epu_opc_t cmt_opc;
   fe_t      cmt_fe;
   pc_t      cmt_pc;
   pc_t      cmt_npc;
   data_t    cmt_addr;
   data_t    cmt_wdat;
   logic     s2_edtm;
   logic     s2_edpf;
   logic     s2_ealign;
   data_t    s2_vaddr;
   data_t    wb_dout;
   logic     wb_dout_sel;
   logic     wb_valid;
   logic     exc_flush;
   pc_t      exc_flush_tgt;
   psr_t     msr_psr;
   int       errors;

   epu_top i_epu_top (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_data(input string name, input data_t act, input data_t exp);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
         errors++;
      end
   endtask

   task automatic check_pc(input string name, input pc_t act, input pc_t exp);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
         errors++;
      end
   endtask

   task automatic check_psr(input string name, input psr_t act, input psr_t exp);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Addresses and expected values

   function automatic data_t ps_addr(input int off);
      data_t addr;
      addr = '0;
      addr[BANK_OFF_AW +: BANK_AW] = BANK_PS;
      addr[off] = 1'b1;
      return addr;
   endfunction

   function automatic data_t sr_addr(input int idx);
      data_t addr;
      addr = '0;
      addr[BANK_OFF_AW +: BANK_AW] = BANK_SR;
      addr[idx] = 1'b1;
      return addr;
   endfunction

   function automatic data_t byte_addr(input pc_t p);
      return {p, {INSN_LEN_LOG2{1'b0}}};
   endfunction

   function automatic data_t psr_word(input psr_t p);
      return {{(DW-PSR_DW){1'b0}}, p};
   endfunction

   // Vector page from EVECT, cause offset below it, as a word PC
   function automatic pc_t vec_target(input data_t evect, input logic [EXCP_VECT_W-1:0] vec);
      data_t tgt;
      tgt = {evect[DW-1:EXCP_VECT_W], vec};
      return tgt[DW-1:INSN_LEN_LOG2];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Drivers

   task automatic clear_inputs;
      cmt_valid = 1'b0;
      cmt_opc   = OPC_NONE;
      cmt_fe    = '0;
      cmt_pc    = '0;
      cmt_npc   = '0;
      cmt_addr  = '0;
      cmt_wdat  = '0;
      s2_edtm   = 1'b0;
      s2_edpf   = 1'b0;
      s2_ealign = 1'b0;
      s2_vaddr  = '0;
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   // Returns once the item sits in the stage register
   task automatic send(input epu_opc_t opc, input fe_t fe, input data_t addr,
                       input data_t wdat, input pc_t pc, input pc_t npc);
      cmt_valid = 1'b1;
      cmt_opc   = opc;
      cmt_fe    = fe;
      cmt_addr  = addr;
      cmt_wdat  = wdat;
      cmt_pc    = pc;
      cmt_npc   = npc;
      next_cycle();
      clear_inputs();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic do_wmsr(input data_t addr, input data_t wdat, input pc_t npc,
                          input logic exp_flush);
      send(OPC_WR, '0, addr, wdat, '0, npc);
      #SAMPLE_DLY;
      check_bit("wb_dout_sel", wb_dout_sel, 1'b0);
      check_bit("exc_flush", exc_flush, exp_flush);
      if (exp_flush)
         check_pc("exc_flush_tgt", exc_flush_tgt, npc);
      next_cycle();
   endtask

   task automatic do_rmsr(input data_t addr, input data_t exp, input string name);
      send(OPC_RD, '0, addr, '0, '0, '0);
      #SAMPLE_DLY;
      check_bit("wb_dout_sel", wb_dout_sel, 1'b1);
      check_bit("wb_valid", wb_valid, 1'b1);
      check_bit("exc_flush", exc_flush, 1'b0);
      check_data(name, wb_dout, exp);
      next_cycle();
   endtask

   task automatic do_exception(input fe_t fe, input pc_t pc, input pc_t npc,
                               input pc_t exp_tgt);
      send(OPC_NONE, fe, '0, '0, pc, npc);
      #SAMPLE_DLY;
      check_bit("exc_flush", exc_flush, 1'b1);
      check_pc("exc_flush_tgt", exc_flush_tgt, exp_tgt);
      next_cycle();
   endtask

   // Fault arrives while the item is in the commit stage
   task automatic do_data_fault(input data_t vaddr, input pc_t exp_tgt);
      send(OPC_NONE, '0, '0, '0, '0, '0);
      s2_edtm  = 1'b1;
      s2_vaddr = vaddr;
      #SAMPLE_DLY;
      check_bit("exc_flush", exc_flush, 1'b1);
      check_pc("exc_flush_tgt", exc_flush_tgt, exp_tgt);
      next_cycle();
      clear_inputs();
   endtask

   task automatic do_eret(input pc_t exp_tgt);
      fe_t fe;
      fe      = '0;
      fe.eret = 1'b1;
      do_exception(fe, '0, '0, exp_tgt);
   endtask

   task automatic do_stall(input pc_t pc, input pc_t npc, input pc_t exp_tgt);
      fe_t  fe;
      psr_t psr_held;
      int   flushes;
      fe          = '0;
      fe.esyscall = 1'b1;
      flushes     = 0;
      psr_held    = msr_psr;
      p_ce_s2     = 1'b0;
      send(OPC_NONE, fe, '0, '0, pc, npc);
      p_ce_s1 = 1'b0;
      repeat (3)
      begin
         #SAMPLE_DLY;
         check_bit("exc_flush", exc_flush, 1'b0);
         check_bit("wb_valid", wb_valid, 1'b0);
         check_psr("msr_psr", msr_psr, psr_held);
         next_cycle();
      end
      p_ce_s1 = 1'b1;
      p_ce_s2 = 1'b1;
      repeat (2)
      begin
         #SAMPLE_DLY;
         if (exc_flush)
         begin
            flushes++;
            check_pc("exc_flush_tgt", exc_flush_tgt, exp_tgt);
         end
         next_cycle();
      end
      if (flushes != 1)
      begin
         $display("Stalled ESYSCALL flushed %0d times instead of once", flushes);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial
   begin
      data_t evect;
      data_t val;
      psr_t  psr_old;
      psr_t  psr_exp;
      pc_t   pc;
      pc_t   npc;
      fe_t   fe;
      errors = 0;
      void'($urandom(SEED));
      clear_inputs();
      p_ce_s1 = 1'b1;
      p_ce_s2 = 1'b1;
      arst_n  = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      arst_n = 1'b1;

      // After reset
      #SAMPLE_DLY;
      check_bit("exc_flush", exc_flush, 1'b0);
      check_bit("wb_valid", wb_valid, 1'b0);
      check_psr("msr_psr", msr_psr, PSR_RST);
      next_cycle();
      do_rmsr(ps_addr(OFF_CPUID), CPUID_VAL, "wb_dout CPUID");
      do_rmsr(ps_addr(OFF_COREID), COREID_VAL, "wb_dout COREID");
      do_rmsr(ps_addr(OFF_EPC), '0, "wb_dout EPC");

      // Register round trip
      val = $urandom;
      do_wmsr(ps_addr(OFF_EPC), val, '0, 1'b0);
      do_rmsr(ps_addr(OFF_EPC), val, "wb_dout EPC");
      val = $urandom;
      do_wmsr(ps_addr(OFF_ELSA), val, '0, 1'b0);
      do_rmsr(ps_addr(OFF_ELSA), val, "wb_dout ELSA");
      val = $urandom;
      do_wmsr(ps_addr(OFF_EPSR), val, '0, 1'b0);
      do_rmsr(ps_addr(OFF_EPSR), psr_word(val[PSR_DW-1:0]), "wb_dout EPSR");
      for (int i = 0; i < SR_NUM; i++)
      begin
         val = $urandom;
         do_wmsr(sr_addr(i), val, '0, 1'b0);
         do_rmsr(sr_addr(i), val, "wb_dout SR");
      end

      // Exception entry, with the PSR enables set first
      evect = $urandom;
      do_wmsr(ps_addr(OFF_EVECT), evect, '0, 1'b0);
      val = $urandom;
      npc = val[PC_W-1:0];
      do_wmsr(ps_addr(OFF_PSR), val | 32'h0000_03F0, npc, 1'b1);
      psr_old     = msr_psr;
      val         = $urandom;
      pc          = val[PC_W-1:0];
      npc         = pc + pc_t'(1);
      fe          = '0;
      fe.esyscall = 1'b1;
      do_exception(fe, pc, npc, vec_target(evect, VEC_ESYSCALL));
      do_rmsr(ps_addr(OFF_EPC), byte_addr(npc), "wb_dout EPC");
      do_rmsr(ps_addr(OFF_EPSR), psr_word(psr_old), "wb_dout EPSR");
      psr_exp      = psr_old;
      psr_exp.rm   = 1'b1;
      psr_exp.ire  = 1'b0;
      psr_exp.imme = 1'b0;
      psr_exp.dmme = 1'b0;
      check_psr("msr_psr", msr_psr, psr_exp);
      val      = $urandom;
      pc       = val[PC_W-1:0];
      fe       = '0;
      fe.einsn = 1'b1;
      do_exception(fe, pc, pc + pc_t'(1), vec_target(evect, VEC_EINSN));
      do_rmsr(ps_addr(OFF_EPC), byte_addr(pc), "wb_dout EPC");
      do_rmsr(ps_addr(OFF_ELSA), byte_addr(pc), "wb_dout ELSA");

      // Data fault
      val = $urandom;
      do_data_fault(val, vec_target(evect, VEC_EDTM));
      do_rmsr(ps_addr(OFF_ELSA), val, "wb_dout ELSA");

      // ERET and PSR write
      val = $urandom;
      do_wmsr(ps_addr(OFF_EPSR), val, '0, 1'b0);
      psr_exp = val[PSR_DW-1:0];
      val     = $urandom;
      do_wmsr(ps_addr(OFF_EPC), val, '0, 1'b0);
      do_eret(val[DW-1:INSN_LEN_LOG2]);
      check_psr("msr_psr", msr_psr, psr_exp);
      psr_old = msr_psr;
      val     = $urandom;
      npc     = val[PC_W-1:0];
      val     = $urandom;
      do_wmsr(ps_addr(OFF_PSR), val, npc, 1'b1);
      psr_exp = psr_old;
      psr_exp[PSR_DW-1:PSR_FLAGS_W] = val[PSR_DW-1:PSR_FLAGS_W];
      check_psr("msr_psr", msr_psr, psr_exp);

      // Stall
      val = $urandom;
      pc  = val[PC_W-1:0];
      npc = pc + pc_t'(1);
      do_stall(pc, npc, vec_target(evect, VEC_ESYSCALL));
      do_rmsr(ps_addr(OFF_EPC), byte_addr(npc), "wb_dout EPC");

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
      $display("Errors: %0d", errors);
      $display("Test failed");
      $finish;
   end

endmodule
